//--- tb.f
hw/eth_tx_pkg.sv
hw/payload_fifo.sv
hw/arp_encoder.sv
hw/ipv4_udp_encoder.sv
hw/frame_encoder.sv
hw/tx_scheduler.sv
hw/eth_tx_top.sv
dv/tb_eth_tx.sv

//--- Makefile
SIM      = verilator
FLAGS    = --binary --timing -Wall --timescale 1ns/1ps
TOP      = tb_eth_tx
FILELIST = tb.f

.PHONY: all lint clean

# build, run, then decide pass or fail from the log
all:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "sim passed" sim.log

lint:
	$(SIM) --lint-only --timing -Wall --timescale 1ns/1ps --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf obj_dir sim.log

//--- dv/tb_eth_tx.sv
module tb_eth_tx;
	timeunit 1ns;
	timeprecision 1ps;
	import eth_tx_pkg::*;

	localparam int wait_limit = 2000; // cycles allowed per wait
	localparam int sel_arp_ack = 0;
	localparam int sel_udp_ack = 1;
	localparam int sel_busy    = 2;

	logic       tx_xcvr_clk;
	logic       arst_n;
	local_cfg_t local_cfg;
	logic       arp_req;
	peer_t      arp_peer;
	logic       arp_ack;
	logic       udp_req;
	udp_desc_t  udp_desc;
	logic       udp_ack;
	logic       payload_wr;
	byte_t      payload_byte;
	logic       payload_full;
	st_tx_t     st_tx;
	logic       st_tx_ready;
	logic       tx_busy;

	byte_t exp_q[$]; // reference frame
	byte_t got_q[$]; // collected frame
	byte_t pay_q[$]; // payload written to the fifo
	int    value_errors;
	int    other_errors;

	eth_tx_top eth_tx_top_inst (
		.tx_xcvr_clk  (tx_xcvr_clk),
		.arst_n       (arst_n),
		.local_cfg    (local_cfg),
		.arp_req      (arp_req),
		.arp_peer     (arp_peer),
		.arp_ack      (arp_ack),
		.udp_req      (udp_req),
		.udp_desc     (udp_desc),
		.udp_ack      (udp_ack),
		.payload_wr   (payload_wr),
		.payload_byte (payload_byte),
		.payload_full (payload_full),
		.st_tx        (st_tx),
		.st_tx_ready  (st_tx_ready),
		.tx_busy      (tx_busy)
	);

	initial
	begin
		tx_xcvr_clk = 1'b0;
		forever #50 tx_xcvr_clk = ~tx_xcvr_clk;
	end

	task automatic check_byte(input string test, input int idx, input byte_t exp,
		input byte_t act);
		if (exp !== act)
		begin
			value_errors++;
			$display("Fail %s: byte %0d expected %h actual %h", test, idx, exp, act);
		end
	endtask

	task automatic check_flag(input string test, input string what, input logic exp,
		input logic act);
		if (exp !== act)
		begin
			value_errors++;
			$display("Fail %s: %s expected %b actual %b", test, what, exp, act);
		end
	endtask

	task automatic check_len(input string test, input string what, input len_t exp,
		input len_t act);
		if (exp !== act)
		begin
			value_errors++;
			$display("Fail %s: %s expected %0d actual %0d", test, what, exp, act);
		end
	endtask

	task automatic note_failure(input string test, input string msg);
		other_errors++;
		$display("Error in %s: %s", test, msg);
	endtask

	function automatic logic watch(input int sel);
		case (sel)
			sel_arp_ack: return arp_ack;
			sel_udp_ack: return udp_ack;
			default:     return tx_busy;
		endcase
	endfunction

	task automatic wait_level(input string test, input string what, input int sel,
		input logic level);
		int n;
		n = 0;
		while (watch(sel) !== level && n < wait_limit)
		begin
			@(negedge tx_xcvr_clk);
			n++;
		end
		if (watch(sel) !== level)
			note_failure(test, $sformatf("%s never went to %0b", what, level));
	endtask

	// four-phase request on the arp or udp side
	task automatic request(input string test, input bit is_udp);
		@(posedge tx_xcvr_clk);
		#5;
		if (is_udp)
			udp_req = 1'b1;
		else
			arp_req = 1'b1;
		wait_level(test, is_udp ? "udp_ack" : "arp_ack",
			is_udp ? sel_udp_ack : sel_arp_ack, 1'b1);
		@(posedge tx_xcvr_clk);
		#5;
		if (is_udp)
			udp_req = 1'b0;
		else
			arp_req = 1'b0;
		wait_level(test, is_udp ? "udp_ack" : "arp_ack",
			is_udp ? sel_udp_ack : sel_arp_ack, 1'b0);
	endtask

	task automatic load_payload(input int n);
		pay_q.delete();
		for (int i = 0; i < n; i++)
		begin
			@(posedge tx_xcvr_clk);
			#5;
			payload_byte = 8'($urandom());
			payload_wr   = 1'b1;
			pay_q.push_back(payload_byte);
		end
		@(posedge tx_xcvr_clk);
		#5;
		payload_wr = 1'b0;
	endtask

	function automatic peer_t random_peer();
		peer_t p;
		p.mac  = {16'($urandom()), $urandom()};
		p.ip   = $urandom();
		p.port = 16'($urandom());
		return p;
	endfunction

	task automatic collect_frame(input string test, input bit random_ready);
		int n;
		bit done;
		n    = 0;
		done = 1'b0;
		got_q.delete();
		while (!done && n < wait_limit)
		begin
			@(posedge tx_xcvr_clk);
			#5;
			st_tx_ready = random_ready ? 1'($urandom_range(1, 0)) : 1'b1;
			@(negedge tx_xcvr_clk);
			if (st_tx.valid && st_tx_ready) // beat transfers on the coming edge
			begin
				check_flag(test, "startofpacket", got_q.size() == 0, st_tx.startofpacket);
				check_flag(test, "tx_busy", 1'b1, tx_busy);
				got_q.push_back(st_tx.data);
				done = st_tx.endofpacket;
			end
			n++;
		end
		if (!done)
			note_failure(test, "no end of packet seen on the output stream");
	endtask

	task automatic push_field(input logic [47:0] v, input int nbytes);
		for (int i = nbytes - 1; i >= 0; i--)
			exp_q.push_back(v[8 * i +: 8]); // msb first
	endtask

	task automatic build_ref(input frame_kind_t kind, input peer_t peer);
		int          n;
		logic [31:0] sum;
		logic [15:0] csum;
		n = pay_q.size();
		exp_q.delete();
		push_field(peer.mac, 6);
		push_field(local_cfg.mac, 6);
		if (kind == kind_arp)
		begin
			push_field(48'h0806, 2);
			push_field(48'h0001_0800_0604, 6); // htype, ptype, hlen, plen
			push_field(48'h0002, 2); // reply
			push_field(local_cfg.mac, 6);
			push_field(48'(local_cfg.ip), 4);
			push_field(peer.mac, 6);
			push_field(48'(peer.ip), 4);
		end
		else
		begin
			push_field(48'h0800, 2);
			push_field(48'h4500, 2);
			push_field(48'(28 + n), 2);
			push_field(48'h0, 4); // id, flags, fragment
			push_field(48'h4011, 2); // ttl 64, proto udp
			push_field(48'h0, 2); // checksum slot
			push_field(48'(local_cfg.ip), 4);
			push_field(48'(peer.ip), 4);
			sum = '0;
			for (int i = 0; i < 10; i++)
				sum += {16'h0, exp_q[14 + 2 * i], exp_q[15 + 2 * i]};
			while (sum[31:16] != 16'h0)
				sum = {16'h0, sum[15:0]} + {16'h0, sum[31:16]};
			csum      = ~sum[15:0];
			exp_q[24] = csum[15:8];
			exp_q[25] = csum[7:0];
			push_field(48'(local_cfg.port), 2);
			push_field(48'(peer.port), 2);
			push_field(48'(8 + n), 2);
			push_field(48'h0, 2);
			foreach (pay_q[i])
				exp_q.push_back(pay_q[i]);
		end
	endtask

	task automatic compare_frame(input string test);
		check_len(test, "frame length", len_t'(exp_q.size()), len_t'(got_q.size()));
		for (int i = 0; i < exp_q.size() && i < got_q.size(); i++)
			check_byte(test, i, exp_q[i], got_q[i]);
	endtask

	task automatic test_reset();
		check_flag("reset", "st_tx.valid", 1'b0, st_tx.valid);
		check_flag("reset", "tx_busy", 1'b0, tx_busy);
		check_flag("reset", "arp_ack", 1'b0, arp_ack);
		check_flag("reset", "udp_ack", 1'b0, udp_ack);
		check_flag("reset", "payload_full", 1'b0, payload_full);
	endtask

	task automatic test_arp();
		peer_t p;
		p = random_peer();
		@(posedge tx_xcvr_clk);
		#5;
		arp_peer = p;
		fork
			request("arp", 1'b0);
			collect_frame("arp", 1'b0);
		join
		build_ref(kind_arp, p);
		compare_frame("arp");
		wait_level("arp", "tx_busy", sel_busy, 1'b0);
	endtask

	task automatic test_udp(input string test, input bit random_ready);
		peer_t p;
		int    n;
		n = $urandom_range(64, 1);
		load_payload(n);
		p        = random_peer();
		udp_desc = '{peer: p, len: len_t'(n)};
		fork
			request(test, 1'b1);
			collect_frame(test, random_ready);
		join
		build_ref(kind_udp, p);
		compare_frame(test);
		wait_level(test, "tx_busy", sel_busy, 1'b0);
	endtask

	// both requests rise on the same cycle, arp goes first
	task automatic test_priority();
		peer_t ap;
		peer_t up;
		int    n;
		n = $urandom_range(64, 1);
		load_payload(n);
		ap       = random_peer();
		up       = random_peer();
		arp_peer = ap;
		udp_desc = '{peer: up, len: len_t'(n)};
		fork
			request("priority", 1'b0);
			request("priority", 1'b1);
			begin
				collect_frame("priority arp", 1'b0);
				build_ref(kind_arp, ap);
				compare_frame("priority arp");
				wait_level("priority", "tx_busy between frames", sel_busy, 1'b0);
				collect_frame("priority udp", 1'b0);
				build_ref(kind_udp, up);
				compare_frame("priority udp");
				wait_level("priority", "tx_busy after frames", sel_busy, 1'b0);
			end
		join
	endtask

	initial
	begin
		void'($urandom(32'hf8c5_3841));
		value_errors = 0;
		other_errors = 0;
		arst_n       = 1'b0;
		local_cfg    = '{mac: 48'h02_00_5e_10_20_30, ip: 32'hc0a8_0164, port: 16'd5000};
		arp_req      = 1'b0;
		arp_peer     = '0;
		udp_req      = 1'b0;
		udp_desc     = '0;
		payload_wr   = 1'b0;
		payload_byte = '0;
		st_tx_ready  = 1'b1;
		repeat (3) @(posedge tx_xcvr_clk);
		#5;
		arst_n = 1'b1;
		@(negedge tx_xcvr_clk);
		test_reset();
		test_arp();
		test_udp("udp", 1'b0);
		test_udp("udp backpressure", 1'b1);
		test_priority();
		$display("value errors: %0d, other errors: %0d", value_errors, other_errors);
		if (value_errors == 0 && other_errors == 0)
			$display("sim passed");
		else
			$display("sim failed");
		$finish;
	end

endmodule

//--- hw/eth_tx_top.sv
module eth_tx_top #(
	parameter int PAYLOAD_AW = 10
) (
	input  logic                   tx_xcvr_clk,
	input  logic                   arst_n,
	input  eth_tx_pkg::local_cfg_t local_cfg,
	input  logic                   arp_req,
	input  eth_tx_pkg::peer_t      arp_peer,
	output logic                   arp_ack,
	input  logic                   udp_req,
	input  eth_tx_pkg::udp_desc_t  udp_desc,
	output logic                   udp_ack,
	input  logic                   payload_wr,
	input  eth_tx_pkg::byte_t      payload_byte,
	output logic                   payload_full,
	output eth_tx_pkg::st_tx_t     st_tx,
	input  logic                   st_tx_ready,
	output logic                   tx_busy
);
	import eth_tx_pkg::*;

	tx_job_t job;
	logic    frame_start;
	logic    frame_done;
	len_t    body_pos;
	logic    body_adv;
	byte_t   arp_byte;
	byte_t   ip_byte;
	logic    payload_rd;
	byte_t   payload_q;

	tx_scheduler tx_scheduler_inst (
		.tx_xcvr_clk (tx_xcvr_clk),
		.arst_n      (arst_n),
		.arp_req     (arp_req),
		.arp_peer    (arp_peer),
		.arp_ack     (arp_ack),
		.udp_req     (udp_req),
		.udp_desc    (udp_desc),
		.udp_ack     (udp_ack),
		.frame_done  (frame_done),
		.frame_start (frame_start),
		.job         (job),
		.tx_busy     (tx_busy)
	);

	frame_encoder frame_encoder_inst (
		.tx_xcvr_clk (tx_xcvr_clk),
		.arst_n      (arst_n),
		.frame_start (frame_start),
		.job         (job),
		.local_cfg   (local_cfg),
		.st_tx_ready (st_tx_ready),
		.st_tx       (st_tx),
		.frame_done  (frame_done),
		.body_pos    (body_pos),
		.body_adv    (body_adv),
		.arp_byte    (arp_byte),
		.ip_byte     (ip_byte)
	);

	arp_encoder arp_encoder_inst (
		.job       (job),
		.local_cfg (local_cfg),
		.body_pos  (body_pos),
		.arp_byte  (arp_byte)
	);

	ipv4_udp_encoder ipv4_udp_encoder_inst (
		.tx_xcvr_clk (tx_xcvr_clk),
		.arst_n      (arst_n),
		.job         (job),
		.local_cfg   (local_cfg),
		.body_pos    (body_pos),
		.body_adv    (body_adv),
		.payload_q   (payload_q),
		.payload_rd  (payload_rd),
		.ip_byte     (ip_byte)
	);

	payload_fifo #(
		.PAYLOAD_AW (PAYLOAD_AW)
	) payload_fifo_inst (
		.tx_xcvr_clk (tx_xcvr_clk),
		.arst_n      (arst_n),
		.wr          (payload_wr),
		.wr_byte     (payload_byte),
		.full        (payload_full),
		.rd          (payload_rd),
		.q           (payload_q)
	);

endmodule

//--- hw/tx_scheduler.sv
module tx_scheduler (
	input  logic                  tx_xcvr_clk,
	input  logic                  arst_n,
	input  logic                  arp_req,
	input  eth_tx_pkg::peer_t     arp_peer,
	output logic                  arp_ack,
	input  logic                  udp_req,
	input  eth_tx_pkg::udp_desc_t udp_desc,
	output logic                  udp_ack,
	input  logic                  frame_done,
	output logic                  frame_start,
	output eth_tx_pkg::tx_job_t   job,
	output logic                  tx_busy
);
	import eth_tx_pkg::*;

	typedef enum logic [1:0] {st_idle, st_busy, st_release} state_t;

	state_t state;
	logic   take_arp;
	logic   take_udp;

	// arp wins when both are pending
	assign take_arp = (state == st_idle) && arp_req;
	assign take_udp = (state == st_idle) && udp_req && !arp_req;

	always_ff @(posedge tx_xcvr_clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			state       <= st_idle;
			frame_start <= 1'b0;
			tx_busy     <= 1'b0;
			arp_ack     <= 1'b0;
			udp_ack     <= 1'b0;
		end
		else
		begin
			frame_start <= take_arp || take_udp;
			case (state)
				st_idle:
				begin
					if (take_arp || take_udp)
					begin
						state   <= st_busy;
						tx_busy <= 1'b1;
					end
				end
				st_busy:
				begin
					if (frame_done)
					begin
						state   <= st_release;
						tx_busy <= 1'b0;
					end
				end
				st_release:
				begin
					if (!arp_ack && !udp_ack) // served handshake fully closed
						state <= st_idle;
				end
				default: state <= st_idle;
			endcase

			if (take_arp)
				arp_ack <= 1'b1;
			else if (!arp_req)
				arp_ack <= 1'b0; // falls one cycle after req drops
			if (take_udp)
				udp_ack <= 1'b1;
			else if (!udp_req)
				udp_ack <= 1'b0;
		end
	end

	always_ff @(posedge tx_xcvr_clk)
	begin
		if (take_arp)
			job <= '{kind: kind_arp, peer: arp_peer, len: '0};
		else if (take_udp)
			job <= '{kind: kind_udp, peer: udp_desc.peer, len: udp_desc.len};
	end

endmodule

//--- hw/frame_encoder.sv
module frame_encoder (
	input  logic                   tx_xcvr_clk,
	input  logic                   arst_n,
	input  logic                   frame_start,
	input  eth_tx_pkg::tx_job_t    job,
	input  eth_tx_pkg::local_cfg_t local_cfg,
	input  logic                   st_tx_ready,
	output eth_tx_pkg::st_tx_t     st_tx,
	output logic                   frame_done,
	output eth_tx_pkg::len_t       body_pos,
	output logic                   body_adv,
	input  eth_tx_pkg::byte_t      arp_byte,
	input  eth_tx_pkg::byte_t      ip_byte
);
	import eth_tx_pkg::*;

	logic         active;
	len_t         pos; // byte index within the frame
	len_t         frame_len;
	logic         in_body;
	logic         last;
	logic         xfer;
	logic [111:0] hdr_word;
	int           hdr_sel;
	byte_t        hdr_byte;

	assign frame_len = (job.kind == kind_arp) ? eth_hdr_len + arp_body_len
		: eth_hdr_len + ip_hdr_len + udp_hdr_len + job.len;
	assign in_body = (pos >= eth_hdr_len);
	assign last    = (pos == frame_len - 1'b1);
	assign xfer    = active && st_tx_ready;

	assign frame_done = xfer && last;
	assign body_adv   = xfer && in_body;
	assign body_pos   = in_body ? pos - eth_hdr_len : '0;

	assign hdr_word = {job.peer.mac, local_cfg.mac,
		(job.kind == kind_arp) ? ethertype_arp : ethertype_ipv4};

	always_comb
	begin
		hdr_sel  = int'(pos[3:0]);
		hdr_byte = '0;
		if (!in_body)
			hdr_byte = hdr_word[8 * (int'(eth_hdr_len) - 1 - hdr_sel) +: 8]; // msb first
	end

	always_comb
	begin
		st_tx.valid         = active;
		st_tx.startofpacket = (pos == '0);
		st_tx.endofpacket   = last;
		if (!in_body)
			st_tx.data = hdr_byte;
		else if (job.kind == kind_arp)
			st_tx.data = arp_byte;
		else
			st_tx.data = ip_byte;
	end

	// position only moves on a transferred beat
	always_ff @(posedge tx_xcvr_clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			active <= 1'b0;
			pos    <= '0;
		end
		else if (frame_start)
		begin
			active <= 1'b1;
			pos    <= '0;
		end
		else if (xfer)
		begin
			pos <= pos + 1'b1;
			if (last)
				active <= 1'b0;
		end
	end

endmodule

//--- hw/ipv4_udp_encoder.sv
module ipv4_udp_encoder (
	input  logic                   tx_xcvr_clk,
	input  logic                   arst_n,
	input  eth_tx_pkg::tx_job_t    job,
	input  eth_tx_pkg::local_cfg_t local_cfg,
	input  eth_tx_pkg::len_t       body_pos,
	input  logic                   body_adv,
	input  eth_tx_pkg::byte_t      payload_q,
	output logic                   payload_rd,
	output eth_tx_pkg::byte_t      ip_byte
);
	import eth_tx_pkg::*;

	localparam len_t hdrs_len = ip_hdr_len + udp_hdr_len; // payload starts here

	len_t         ip_total;
	len_t         udp_len;
	logic [159:0] ip_hdr_nock; // checksum field zero
	logic [63:0]  udp_hdr;
	logic [223:0] hdr_word;
	logic [19:0]  csum_acc;
	logic [16:0]  csum_fold;
	logic [15:0]  csum_next;
	logic [15:0]  hdr_csum;
	int           sel;

	assign ip_total = hdrs_len + job.len;
	assign udp_len  = udp_hdr_len + job.len;

	assign ip_hdr_nock = {ip_ver_ihl, 8'h00, 16'(ip_total), 16'h0000, 16'h0000,
		ip_ttl, ip_proto_udp, 16'h0000, local_cfg.ip, job.peer.ip};
	assign udp_hdr = {local_cfg.port, job.peer.port, 16'(udp_len), 16'h0000}; // no udp checksum
	assign hdr_word = {ip_hdr_nock[159:80], hdr_csum, ip_hdr_nock[63:0], udp_hdr};

	// ones' complement sum of the ten header words, folded twice
	always_comb
	begin
		csum_acc = '0;
		for (int i = 0; i < 10; i++)
			csum_acc = csum_acc + 20'(ip_hdr_nock[16 * i +: 16]);
		csum_fold = 17'(csum_acc[15:0]) + 17'(csum_acc[19:16]);
		csum_next = ~(csum_fold[15:0] + 16'(csum_fold[16]));
	end

	// job is stable through the ethernet header, so the sum is settled here
	always_ff @(posedge tx_xcvr_clk or negedge arst_n)
	begin
		if (!arst_n)
			hdr_csum <= '0;
		else if (body_pos == '0)
			hdr_csum <= csum_next;
	end

	always_comb
	begin
		sel     = int'(body_pos[4:0]);
		ip_byte = payload_q; // show-ahead head of the fifo
		if (body_pos < hdrs_len)
			ip_byte = hdr_word[8 * (int'(hdrs_len) - 1 - sel) +: 8];
	end

	assign payload_rd = body_adv && (job.kind == kind_udp) && (body_pos >= hdrs_len);

endmodule

//--- hw/arp_encoder.sv
module arp_encoder (
	input  eth_tx_pkg::tx_job_t    job,
	input  eth_tx_pkg::local_cfg_t local_cfg,
	input  eth_tx_pkg::len_t       body_pos,
	output eth_tx_pkg::byte_t      arp_byte
);
	import eth_tx_pkg::*;

	logic [223:0] body_word; // 28 bytes, first byte in the top bits
	int           sel;

	// reply: we are the sender, the requester is the target
	assign body_word = {
		arp_htype_eth,
		ethertype_ipv4,
		arp_hlen,
		arp_plen,
		arp_oper_reply,
		local_cfg.mac,
		local_cfg.ip,
		job.peer.mac,
		job.peer.ip
	};

	always_comb
	begin
		sel      = int'(body_pos[4:0]);
		arp_byte = '0;
		if (body_pos < arp_body_len)
			arp_byte = body_word[8 * (int'(arp_body_len) - 1 - sel) +: 8];
	end

endmodule

//--- hw/payload_fifo.sv
module payload_fifo #(
	parameter int PAYLOAD_AW = 10
) (
	input  logic              tx_xcvr_clk,
	input  logic              arst_n,
	input  logic              wr,
	input  eth_tx_pkg::byte_t wr_byte,
	output logic              full,
	input  logic              rd,
	output eth_tx_pkg::byte_t q
);
	import eth_tx_pkg::*;

	byte_t                 mem [2**PAYLOAD_AW];
	logic [PAYLOAD_AW:0]   wr_ptr; // extra msb tells full from empty
	logic [PAYLOAD_AW:0]   rd_ptr;
	logic                  empty;

	assign empty = (wr_ptr == rd_ptr);
	assign full  = (wr_ptr[PAYLOAD_AW] != rd_ptr[PAYLOAD_AW])
		&& (wr_ptr[PAYLOAD_AW-1:0] == rd_ptr[PAYLOAD_AW-1:0]);
	assign q     = mem[rd_ptr[PAYLOAD_AW-1:0]];

	always_ff @(posedge tx_xcvr_clk)
	begin
		if (wr && !full)
			mem[wr_ptr[PAYLOAD_AW-1:0]] <= wr_byte;
	end

	always_ff @(posedge tx_xcvr_clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end
		else
		begin
			if (wr && !full)
				wr_ptr <= wr_ptr + 1'b1;
			if (rd && !empty)
				rd_ptr <= rd_ptr + 1'b1;
		end
	end

endmodule

//--- hw/eth_tx_pkg.sv
package eth_tx_pkg;

	typedef logic [7:0]  byte_t;
	typedef logic [47:0] mac_t;
	typedef logic [31:0] ip_t;
	typedef logic [15:0] port_t;
	typedef logic [10:0] len_t; // byte count, up to 2047

	typedef struct packed {
		mac_t  mac;
		ip_t   ip;
		port_t port;
	} peer_t;

	typedef struct packed {
		mac_t  mac;
		ip_t   ip;
		port_t port; // udp source port
	} local_cfg_t;

	typedef struct packed {
		peer_t peer;
		len_t  len; // payload bytes already in the fifo
	} udp_desc_t;

	typedef enum logic {kind_arp, kind_udp} frame_kind_t;

	typedef struct packed {
		frame_kind_t kind;
		peer_t       peer;
		len_t        len;
	} tx_job_t;

	typedef struct packed {
		logic  valid;
		logic  startofpacket;
		logic  endofpacket;
		byte_t data;
	} st_tx_t;

	localparam logic [15:0] ethertype_arp  = 16'h0806;
	localparam logic [15:0] ethertype_ipv4 = 16'h0800;

	localparam logic [15:0] arp_htype_eth  = 16'h0001;
	localparam byte_t       arp_hlen       = 8'd6;
	localparam byte_t       arp_plen       = 8'd4;
	localparam logic [15:0] arp_oper_reply = 16'h0002;

	localparam len_t  arp_body_len = 11'd28;
	localparam len_t  ip_hdr_len   = 11'd20;
	localparam len_t  udp_hdr_len  = 11'd8;
	localparam len_t  eth_hdr_len  = 11'd14;
	localparam byte_t ip_ver_ihl   = 8'h45; // version 4, five words
	localparam byte_t ip_ttl       = 8'd64;
	localparam byte_t ip_proto_udp = 8'd17;

endpackage
